/* pong_cfg.svh */
`ifndef PONG_CFG_SVH
`define PONG_CFG_SVH

// playfield limits
`define PONG_X_MAX        639
`define PONG_Y_MAX        479
`define PONG_X_START      320     // serve point
`define PONG_Y_START      240
`define PONG_PADDLE_X     16      // paddle column

// solo defaults
`define PONG_DEF_SPEED    4
`define PONG_DEF_GRAVITY  1

// link register map, one word apart
`define PONG_ADDR_Y0      8'h00
`define PONG_ADDR_Y1      8'h04
`define PONG_ADDR_VY      8'h08
`define PONG_ADDR_GRAVITY 8'h0C
`define PONG_ADDR_SPEED   8'h10
`define PONG_ADDR_WIN     8'h14
`define PONG_ADDR_GO      8'h18

`endif

/* pong_pkg.sv */
`default_nettype none

package pong_pkg;

    typedef logic        [9:0] coord_t;   // screen coordinate
    typedef logic signed [7:0] vel_t;     // vertical velocity
    typedef logic        [7:0] grav_t;
    typedef logic        [7:0] speed_t;   // x step per frame

    // --------------------------------------------------
    // ball state, 31 bits
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        vel_t       vy;
        logic       moving_left;
        logic [1:0] gravity_counter;
    } ball_state_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // register content seen by the duel controller
    typedef struct packed {
        coord_t y;
        vel_t   vy;
        grav_t  gravity;
        speed_t speed;
        logic   win_flag;
        logic   arrive;       // one cycle after a GO write
    } link_cfg_t;

    // --------------------------------------------------
    typedef enum logic [1:0] {
        S_IDLE,
        S_PLAY,
        S_OVER
    } solo_state_e;

    typedef enum logic [2:0] {
        D_IDLE,
        D_HOLD,    // departing ball on the link
        D_PLAY,
        D_AWAY,
        D_WIN,
        D_LOSE
    } duel_state_e;

endpackage

`default_nettype wire

/* ball_motion.sv */
`default_nettype none
`include "pong_cfg.svh"

module ball_motion (
    input  wire                        clk_25MHZ,
    input  wire                        arst_n,
    input  wire                        step,
    input  wire                        load,
    input  wire pong_pkg::ball_state_t load_state,
    input  wire                        reverse_x,
    input  wire pong_pkg::speed_t      speed,
    input  wire pong_pkg::grav_t       gravity,
    output pong_pkg::ball_state_t      ball
);

    logic signed [9:0]  vy_sum;
    pong_pkg::vel_t     vy_grav;
    pong_pkg::vel_t     vy_next;
    logic signed [11:0] y_sum;
    pong_pkg::coord_t   y_next;
    logic               left_next;
    logic [10:0]        x_sum;
    pong_pkg::coord_t   x_next;

    // --------------------------------------------------
    // next state
    always_comb begin
        vy_sum = {{2{ball.vy[7]}}, ball.vy} + {2'b00, gravity};
        if (ball.gravity_counter != 2'd3) begin
            vy_grav = ball.vy;                  // no gravity this frame
        end else if (vy_sum > 10'sd127) begin
            vy_grav = 8'sd127;
        end else if (vy_sum < -10'sd127) begin
            vy_grav = -8'sd127;
        end else begin
            vy_grav = vy_sum[7:0];
        end

        // top and bottom walls
        y_sum = {2'b00, ball.y} + {{4{vy_grav[7]}}, vy_grav};
        if (y_sum < 0) begin
            y_next  = '0;
            vy_next = -vy_grav;
        end else if (y_sum > `PONG_Y_MAX) begin
            y_next  = 10'(`PONG_Y_MAX);
            vy_next = -vy_grav;
        end else begin
            y_next  = y_sum[9:0];
            vy_next = vy_grav;
        end

        left_next = ball.moving_left ^ reverse_x;   // flip before the move
        x_sum     = {1'b0, ball.x} + 11'(speed);
        if (left_next) begin
            x_next = (ball.x > 10'(speed)) ? ball.x - 10'(speed) : '0;
        end else if (x_sum > `PONG_X_MAX) begin
            x_next = 10'(`PONG_X_MAX);
        end else begin
            x_next = x_sum[9:0];
        end
    end

    always_ff @(posedge clk_25MHZ or negedge arst_n) begin
        if (!arst_n) begin
            ball.x               <= 10'(`PONG_X_START);
            ball.y               <= 10'(`PONG_Y_START);
            ball.vy              <= '0;
            ball.moving_left     <= 1'b1;
            ball.gravity_counter <= 2'd0;
        end else if (load) begin
            ball <= load_state;
        end else if (step) begin
            ball.x               <= x_next;
            ball.y               <= y_next;
            ball.vy              <= vy_next;
            ball.moving_left     <= left_next;
            ball.gravity_counter <= ball.gravity_counter + 2'd1;
        end else if (reverse_x) begin
            ball.moving_left <= ~ball.moving_left;
        end
    end

endmodule

`default_nettype wire

/* game_solo_ctrl.sv */
`default_nettype none
`include "pong_cfg.svh"

module game_solo_ctrl (
    input  wire                   clk_25MHZ,
    input  wire                   arst_n,
    input  wire                   frame_tick,
    input  wire                   game_start,
    input  wire                   collision_detected,
    output pong_pkg::ball_state_t ball,
    output logic                  game_over,
    output logic                  is_collusion
);

    pong_pkg::solo_state_e state;
    pong_pkg::ball_state_t serve;
    logic                  at_right;
    logic                  at_paddle;
    logic                  play_tick;
    logic                  miss;
    logic                  step;
    logic                  load;
    logic                  reverse_x;

    assign serve = '{x: 10'(`PONG_X_START), y: 10'(`PONG_Y_START), vy: '0,
                     moving_left: 1'b1, gravity_counter: 2'd0};

    // edge decisions on the registered ball
    assign at_right  = !ball.moving_left && (ball.x >= `PONG_X_MAX);
    assign at_paddle = ball.moving_left && (ball.x <= `PONG_PADDLE_X);
    assign play_tick = (state == pong_pkg::S_PLAY) && frame_tick;
    assign miss      = play_tick && at_paddle && !collision_detected;
    assign load      = game_start && (state != pong_pkg::S_PLAY);
    assign step      = play_tick && !miss;
    assign reverse_x = play_tick && (at_right || (at_paddle && collision_detected));
    assign game_over = (state == pong_pkg::S_OVER);

    always_ff @(posedge clk_25MHZ or negedge arst_n) begin
        if (!arst_n) begin
            state        <= pong_pkg::S_IDLE;
            is_collusion <= 1'b0;
        end else begin
            is_collusion <= play_tick && at_paddle && collision_detected;
            case (state)
                pong_pkg::S_IDLE,
                pong_pkg::S_OVER: if (game_start) state <= pong_pkg::S_PLAY;
                pong_pkg::S_PLAY: if (miss) state <= pong_pkg::S_OVER;
                default:          state <= pong_pkg::S_IDLE;
            endcase
        end
    end

    ball_motion u_ball_motion (
        .clk_25MHZ (clk_25MHZ),
        .arst_n    (arst_n),
        .step      (step),
        .load      (load),
        .load_state(serve),
        .reverse_x (reverse_x),
        .speed     (pong_pkg::speed_t'(`PONG_DEF_SPEED)),
        .gravity   (pong_pkg::grav_t'(`PONG_DEF_GRAVITY)),
        .ball      (ball)
    );

endmodule

`default_nettype wire

/* game_duel_ctrl.sv */
`default_nettype none
`include "pong_cfg.svh"

module game_duel_ctrl (
    input  wire                        clk_25MHZ,
    input  wire                        arst_n,
    input  wire                        frame_tick,
    input  wire                        game_start,
    input  wire                        collision_detected,
    input  wire pong_pkg::link_cfg_t   link,
    output pong_pkg::ball_state_t      ball,
    output logic                       game_over,
    output logic                       ball_send_trigger,
    output logic                       is_collusion,
    output logic                       is_you_win,
    output logic                       is_lose,
    output logic                       is_idle
);

    pong_pkg::duel_state_e state;
    pong_pkg::ball_state_t serve;
    pong_pkg::ball_state_t catch_ball;
    logic                  can_serve;
    logic                  at_right;
    logic                  at_paddle;
    logic                  play_tick;
    logic                  miss;
    logic                  step;
    logic                  load;
    logic                  reverse_x;

    assign serve      = '{x: 10'(`PONG_X_START), y: 10'(`PONG_Y_START), vy: '0,
                          moving_left: 1'b1, gravity_counter: 2'd0};
    assign catch_ball = '{x: 10'(`PONG_X_MAX), y: link.y, vy: link.vy,
                          moving_left: 1'b1, gravity_counter: 2'd0};   // enters at right edge

    assign can_serve = (state == pong_pkg::D_IDLE) || (state == pong_pkg::D_WIN)
                    || (state == pong_pkg::D_LOSE);
    assign at_right  = !ball.moving_left && (ball.x >= `PONG_X_MAX);
    assign at_paddle = ball.moving_left && (ball.x <= `PONG_PADDLE_X);
    assign play_tick = (state == pong_pkg::D_PLAY) && frame_tick;
    assign miss      = play_tick && at_paddle && !collision_detected;

    // ball freezes while it leaves or after a miss
    assign step      = play_tick && !miss && !at_right;
    assign reverse_x = play_tick && at_paddle && collision_detected;
    assign load      = (game_start && can_serve) || ((state == pong_pkg::D_AWAY) && link.arrive);

    // --------------------------------------------------
    // status decode
    assign ball_send_trigger = (state == pong_pkg::D_HOLD);
    assign is_idle    = (state == pong_pkg::D_IDLE) || (state == pong_pkg::D_AWAY);
    assign is_you_win = (state == pong_pkg::D_WIN);
    assign is_lose    = (state == pong_pkg::D_LOSE);
    assign game_over  = is_lose;

    always_ff @(posedge clk_25MHZ or negedge arst_n) begin
        if (!arst_n) begin
            state        <= pong_pkg::D_IDLE;
            is_collusion <= 1'b0;
        end else begin
            is_collusion <= reverse_x;
            case (state)
                pong_pkg::D_IDLE,
                pong_pkg::D_WIN,
                pong_pkg::D_LOSE: if (game_start) state <= pong_pkg::D_PLAY;
                pong_pkg::D_PLAY: begin
                    if (miss) state <= pong_pkg::D_LOSE;
                    else if (play_tick && at_right) state <= pong_pkg::D_HOLD;
                end
                pong_pkg::D_HOLD: state <= pong_pkg::D_AWAY;   // one-cycle send
                pong_pkg::D_AWAY: begin
                    if (link.arrive) state <= pong_pkg::D_PLAY;
                    else if (link.win_flag) state <= pong_pkg::D_WIN;
                end
                default: state <= pong_pkg::D_IDLE;
            endcase
        end
    end

    ball_motion u_ball_motion (
        .clk_25MHZ (clk_25MHZ),
        .arst_n    (arst_n),
        .step      (step),
        .load      (load),
        .load_state(can_serve ? serve : catch_ball),
        .reverse_x (reverse_x),
        .speed     (link.speed),
        .gravity   (link.gravity),
        .ball      (ball)
    );

endmodule

`default_nettype wire

/* ball_link_regs.sv */
`default_nettype none
`include "pong_cfg.svh"

module ball_link_regs (
    input  wire                      clk_25MHZ,
    input  wire                      arst_n,
    input  wire pong_pkg::apb_req_t  apb,
    output logic [31:0]              prdata,
    output pong_pkg::link_cfg_t      link
);

    logic [7:0] y0_q;
    logic [7:0] y1_q;
    logic [7:0] vy_q;
    logic [7:0] grav_q;
    logic [7:0] speed_q;
    logic [7:0] win_q;
    logic       arrive_q;
    logic       wr_en;

    assign wr_en = apb.psel && apb.penable && apb.pwrite;   // access phase

    always_ff @(posedge clk_25MHZ or negedge arst_n) begin
        if (!arst_n) begin
            y0_q     <= '0;
            y1_q     <= '0;
            vy_q     <= '0;
            grav_q   <= 8'(`PONG_DEF_GRAVITY);
            speed_q  <= 8'(`PONG_DEF_SPEED);
            win_q    <= '0;
            arrive_q <= 1'b0;
        end else begin
            arrive_q <= wr_en && (apb.paddr == `PONG_ADDR_GO);
            if (wr_en) begin
                case (apb.paddr)
                    `PONG_ADDR_Y0:      y0_q    <= apb.pwdata[7:0];
                    `PONG_ADDR_Y1:      y1_q    <= apb.pwdata[7:0];
                    `PONG_ADDR_VY:      vy_q    <= apb.pwdata[7:0];
                    `PONG_ADDR_GRAVITY: grav_q  <= apb.pwdata[7:0];
                    `PONG_ADDR_SPEED:   speed_q <= apb.pwdata[7:0];
                    `PONG_ADDR_WIN:     win_q   <= apb.pwdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // read mux, GO and holes read 0
    always_comb begin
        prdata = '0;
        if (apb.psel && !apb.pwrite) begin
            case (apb.paddr)
                `PONG_ADDR_Y0:      prdata[7:0] = y0_q;
                `PONG_ADDR_Y1:      prdata[7:0] = y1_q;
                `PONG_ADDR_VY:      prdata[7:0] = vy_q;
                `PONG_ADDR_GRAVITY: prdata[7:0] = grav_q;
                `PONG_ADDR_SPEED:   prdata[7:0] = speed_q;
                `PONG_ADDR_WIN:     prdata[7:0] = win_q;
                default:            prdata      = '0;
            endcase
        end
    end

    assign link = '{y: {y1_q[1:0], y0_q}, vy: pong_pkg::vel_t'(vy_q), gravity: grav_q,
                    speed: speed_q, win_flag: win_q[0], arrive: arrive_q};

endmodule

`default_nettype wire

/* top_game_controller.sv */
`default_nettype none

module top_game_controller (
    input  wire                     clk_25MHZ,
    input  wire                     arst_n,
    input  wire                     sw,            // 0 solo, 1 duel
    input  wire                     frame_tick,
    input  wire                     game_start,
    input  wire                     collision_detected,
    input  wire pong_pkg::apb_req_t apb,
    output logic [31:0]             prdata,
    output pong_pkg::coord_t        ball_x_out,
    output pong_pkg::coord_t        ball_y_out,
    output logic                    is_ball_moving_left,
    output logic                    is_ball_moving_right,
    output logic                    game_over,
    output logic                    ball_send_trigger,
    output pong_pkg::vel_t          ball_vy,
    output logic [1:0]              gravity_counter,
    output logic                    is_collusion,
    output logic                    is_you_win,
    output logic                    is_idle,
    output logic                    is_lose
);

    pong_pkg::ball_state_t ball_solo;
    pong_pkg::ball_state_t ball_duel;
    pong_pkg::ball_state_t ball_sel;
    pong_pkg::link_cfg_t   link;
    logic                  game_over_solo;
    logic                  game_over_duel;
    logic                  collusion_solo;
    logic                  collusion_duel;

    // --------------------------------------------------
    // mode mux
    assign ball_sel     = sw ? ball_duel : ball_solo;
    assign game_over    = sw ? game_over_duel : game_over_solo;
    assign is_collusion = sw ? collusion_duel : collusion_solo;

    assign ball_x_out           = ball_sel.x;
    assign ball_y_out           = ball_sel.y;
    assign ball_vy              = ball_sel.vy;
    assign gravity_counter      = ball_sel.gravity_counter;
    assign is_ball_moving_left  = ball_sel.moving_left;
    assign is_ball_moving_right = !ball_sel.moving_left && !(sw && is_idle);  // not while away

    game_solo_ctrl u_game_solo_ctrl (
        .clk_25MHZ         (clk_25MHZ),
        .arst_n            (arst_n),
        .frame_tick        (frame_tick),
        .game_start        (game_start),
        .collision_detected(collision_detected),
        .ball              (ball_solo),
        .game_over         (game_over_solo),
        .is_collusion      (collusion_solo)
    );

    game_duel_ctrl u_game_duel_ctrl (
        .clk_25MHZ         (clk_25MHZ),
        .arst_n            (arst_n),
        .frame_tick        (frame_tick),
        .game_start        (game_start),
        .collision_detected(collision_detected),
        .link              (link),
        .ball              (ball_duel),
        .game_over         (game_over_duel),
        .ball_send_trigger (ball_send_trigger),
        .is_collusion      (collusion_duel),
        .is_you_win        (is_you_win),
        .is_lose           (is_lose),
        .is_idle           (is_idle)
    );

    ball_link_regs u_ball_link_regs (
        .clk_25MHZ(clk_25MHZ),
        .arst_n   (arst_n),
        .apb      (apb),
        .prdata   (prdata),
        .link     (link)
    );

endmodule

`default_nettype wire

/* tb_top_game_controller.sv */
`default_nettype none
`include "pong_cfg.svh"

module tb_top_game_controller;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAMES_MAX   = 400;
    localparam int FRAME_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int TIMEOUT_NS   = FRAMES_MAX * FRAME_CYCLES * NUM_TESTS * 2 * 10;

    logic                  clk_25MHZ;
    logic                  arst_n;
    logic                  sw;
    logic                  frame_tick;
    logic                  game_start;
    logic                  collision_detected;
    pong_pkg::apb_req_t    apb;
    logic [31:0]           prdata;
    pong_pkg::coord_t      ball_x_out;
    pong_pkg::coord_t      ball_y_out;
    logic                  is_ball_moving_left;
    logic                  is_ball_moving_right;
    logic                  game_over;
    logic                  ball_send_trigger;
    pong_pkg::vel_t        ball_vy;
    logic [1:0]            gravity_counter;
    logic                  is_collusion;
    logic                  is_you_win;
    logic                  is_idle;
    logic                  is_lose;

    // reference model state
    pong_pkg::ball_state_t solo_mdl;
    pong_pkg::ball_state_t duel_mdl;
    pong_pkg::solo_state_e solo_st;
    pong_pkg::duel_state_e duel_st;
    int                    link_speed;
    int                    link_grav;
    logic [7:0]            link_y0;
    logic [7:0]            link_y1;
    logic [7:0]            link_vy;
    logic                  link_win;

    int                    n_checks;
    int                    n_errors;
    int                    test_errors;
    int                    test_num;
    int                    trig_count;
    pong_pkg::vel_t        trig_vy;
    logic [1:0]            trig_gc;
    int unsigned           seed_val;

    top_game_controller dut0 (
        .clk_25MHZ           (clk_25MHZ),
        .arst_n              (arst_n),
        .sw                  (sw),
        .frame_tick          (frame_tick),
        .game_start          (game_start),
        .collision_detected  (collision_detected),
        .apb                 (apb),
        .prdata              (prdata),
        .ball_x_out          (ball_x_out),
        .ball_y_out          (ball_y_out),
        .is_ball_moving_left (is_ball_moving_left),
        .is_ball_moving_right(is_ball_moving_right),
        .game_over           (game_over),
        .ball_send_trigger   (ball_send_trigger),
        .ball_vy             (ball_vy),
        .gravity_counter     (gravity_counter),
        .is_collusion        (is_collusion),
        .is_you_win          (is_you_win),
        .is_idle             (is_idle),
        .is_lose             (is_lose)
    );

    always #5 clk_25MHZ = ~clk_25MHZ;

    // departing ball, sampled mid-cycle
    always @(negedge clk_25MHZ) begin
        if (ball_send_trigger) begin
            trig_count = trig_count + 1;
            trig_vy    = ball_vy;
            trig_gc    = gravity_counter;
        end
    end

    // --------------------------------------------------
    // model helpers
    function automatic pong_pkg::ball_state_t serve_ball();
        pong_pkg::ball_state_t b;
        b.x               = `PONG_X_START;
        b.y               = `PONG_Y_START;
        b.vy              = '0;
        b.moving_left     = 1'b1;
        b.gravity_counter = 2'd0;
        return b;
    endfunction

    function automatic bit at_paddle(pong_pkg::ball_state_t b);
        return b.moving_left && (b.x <= `PONG_PADDLE_X);
    endfunction

    function automatic bit at_right(pong_pkg::ball_state_t b);
        return !b.moving_left && (b.x >= `PONG_X_MAX);
    endfunction

    function automatic pong_pkg::ball_state_t move_ball(pong_pkg::ball_state_t b, int spd,
                                                        int grv, bit rev);
        int vy;
        int y;
        int x;
        vy = $signed(b.vy);
        if (b.gravity_counter == 2'd3) begin
            vy = vy + grv;
            if (vy > 127) vy = 127;
            if (vy < -127) vy = -127;
        end
        y = int'(b.y) + vy;
        if (y < 0) begin
            y  = 0;
            vy = -vy;
        end else if (y > `PONG_Y_MAX) begin
            y  = `PONG_Y_MAX;
            vy = -vy;
        end
        b.moving_left = b.moving_left ^ rev;
        x = b.moving_left ? int'(b.x) - spd : int'(b.x) + spd;
        if (x < 0) x = 0;
        if (x > `PONG_X_MAX) x = `PONG_X_MAX;
        b.x               = x[9:0];
        b.y               = y[9:0];
        b.vy              = vy[7:0];
        b.gravity_counter = b.gravity_counter + 2'd1;
        return b;
    endfunction

    task automatic advance_models(bit coll);
        if (solo_st == pong_pkg::S_PLAY) begin
            if (at_paddle(solo_mdl) && !coll) begin
                solo_st = pong_pkg::S_OVER;
            end else begin
                solo_mdl = move_ball(solo_mdl, `PONG_DEF_SPEED, `PONG_DEF_GRAVITY,
                                     at_right(solo_mdl) || (at_paddle(solo_mdl) && coll));
            end
        end
        if (duel_st == pong_pkg::D_PLAY) begin
            if (at_paddle(duel_mdl) && !coll) begin
                duel_st = pong_pkg::D_LOSE;
            end else if (at_right(duel_mdl)) begin
                duel_st = link_win ? pong_pkg::D_WIN : pong_pkg::D_AWAY;  // frozen while sent
            end else begin
                duel_mdl = move_ball(duel_mdl, link_speed, link_grav,
                                     at_paddle(duel_mdl) && coll);
            end
        end
    endtask

    // --------------------------------------------------
    // checker and stimulus
    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_ports();
        pong_pkg::ball_state_t exp;
        bit                    duel_idle;
        bit                    exp_over;
        exp       = sw ? duel_mdl : solo_mdl;
        duel_idle = (duel_st == pong_pkg::D_IDLE) || (duel_st == pong_pkg::D_AWAY);
        exp_over  = sw ? (duel_st == pong_pkg::D_LOSE) : (solo_st == pong_pkg::S_OVER);
        check("ball_x_out", ball_x_out, exp.x);
        check("ball_y_out", ball_y_out, exp.y);
        check("ball_vy", ball_vy, exp.vy);
        check("gravity_counter", gravity_counter, exp.gravity_counter);
        check("is_ball_moving_left", is_ball_moving_left, exp.moving_left);
        check("is_ball_moving_right", is_ball_moving_right,
              !exp.moving_left && !(sw && duel_idle));
        check("game_over", game_over, exp_over);
        check("is_idle", is_idle, duel_idle);
        check("is_you_win", is_you_win, duel_st == pong_pkg::D_WIN);
        check("is_lose", is_lose, duel_st == pong_pkg::D_LOSE);
    endtask

    task automatic do_frame(bit never_hit);
        pong_pkg::ball_state_t sel;
        bit                    coll;
        bit                    hit;
        sel = sw ? duel_mdl : solo_mdl;
        if (never_hit) coll = 1'b0;
        else if (at_paddle(sel)) coll = 1'b1;
        else coll = 1'($urandom % 2);
        hit = coll && at_paddle(sel)
              && (sw ? (duel_st == pong_pkg::D_PLAY) : (solo_st == pong_pkg::S_PLAY));
        @(posedge clk_25MHZ);
        #1;
        frame_tick         = 1'b1;
        collision_detected = coll;
        advance_models(coll);
        @(posedge clk_25MHZ);
        #1 frame_tick = 1'b0;
        check("is_collusion", is_collusion, hit);    // paddle hit pulse
        @(posedge clk_25MHZ);
        #1 compare_ports();
        repeat (FRAME_CYCLES - 3) @(posedge clk_25MHZ);
    endtask

    task automatic start_game();
        @(posedge clk_25MHZ);
        #1 game_start = 1'b1;
        if (solo_st != pong_pkg::S_PLAY) begin
            solo_mdl = serve_ball();
            solo_st  = pong_pkg::S_PLAY;
        end
        if (duel_st == pong_pkg::D_IDLE || duel_st == pong_pkg::D_WIN
                || duel_st == pong_pkg::D_LOSE) begin
            duel_mdl = serve_ball();
            duel_st  = pong_pkg::D_PLAY;
        end
        @(posedge clk_25MHZ);
        #1 game_start = 1'b0;
        @(posedge clk_25MHZ);
        #1 compare_ports();
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        @(posedge clk_25MHZ);
        #1 apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk_25MHZ);
        #1 apb.penable = 1'b1;
        @(posedge clk_25MHZ);
        #1 apb = '0;
        case (addr)
            `PONG_ADDR_Y0:      link_y0 = data[7:0];
            `PONG_ADDR_Y1:      link_y1 = data[7:0];
            `PONG_ADDR_VY:      link_vy = data[7:0];
            `PONG_ADDR_GRAVITY: link_grav = data[7:0];
            `PONG_ADDR_SPEED:   link_speed = data[7:0];
            `PONG_ADDR_WIN:     link_win = data[0];
            default: ;
        endcase
        if (duel_st == pong_pkg::D_AWAY && addr == `PONG_ADDR_GO) begin
            duel_mdl = '{x: `PONG_X_MAX, y: {link_y1[1:0], link_y0}, vy: link_vy,
                         moving_left: 1'b1, gravity_counter: 2'd0};
            duel_st  = pong_pkg::D_PLAY;
        end else if (duel_st == pong_pkg::D_AWAY && link_win) begin
            duel_st = pong_pkg::D_WIN;
        end
    endtask

    task automatic apb_read(logic [7:0] addr, output logic [31:0] data);
        @(posedge clk_25MHZ);
        #1 apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk_25MHZ);
        #1 apb.penable = 1'b1;
        #4 data = prdata;     // mid access cycle
        @(posedge clk_25MHZ);
        #1 apb = '0;
    endtask

    task automatic end_test(string name);
        test_num = test_num + 1;
        $display("test %0d %s: %0d errors", test_num, name, n_errors - test_errors);
        test_errors = n_errors;
    endtask

    // --------------------------------------------------
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the run hung");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [7:0]  wval;
        logic [7:0]  addrs [6];
        int          y_val;
        int          vy_val;
        int          n;
        seed_val    = $urandom(32'h060c_20aa);
        clk_25MHZ   = 1'b0;
        arst_n      = 1'b0;
        sw          = 1'b0;
        frame_tick  = 1'b0;
        game_start  = 1'b0;
        collision_detected = 1'b0;
        apb         = '0;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;
        test_num    = 0;
        trig_count  = 0;
        solo_mdl    = serve_ball();
        duel_mdl    = serve_ball();
        solo_st     = pong_pkg::S_IDLE;
        duel_st     = pong_pkg::D_IDLE;
        link_speed  = `PONG_DEF_SPEED;
        link_grav   = `PONG_DEF_GRAVITY;
        link_y0     = '0;
        link_y1     = '0;
        link_vy     = '0;
        link_win    = 1'b0;
        repeat (16) @(posedge clk_25MHZ);
        #1 arst_n = 1'b1;

        // register block
        apb_read(`PONG_ADDR_SPEED, rd);
        check("prdata speed", rd, `PONG_DEF_SPEED);
        apb_read(`PONG_ADDR_GRAVITY, rd);
        check("prdata gravity", rd, `PONG_DEF_GRAVITY);
        addrs = '{`PONG_ADDR_Y0, `PONG_ADDR_Y1, `PONG_ADDR_VY, `PONG_ADDR_GRAVITY,
                  `PONG_ADDR_SPEED, `PONG_ADDR_WIN};
        foreach (addrs[i]) begin
            wval = 8'($urandom);
            apb_write(addrs[i], {24'($urandom), wval});
            apb_read(addrs[i], rd);
            check("prdata", rd, {24'h0, wval});
        end
        apb_read(`PONG_ADDR_GO, rd);
        check("prdata go", rd, 32'h0);
        apb_read(8'h1C, rd);
        check("prdata unmapped", rd, 32'h0);
        apb_write(`PONG_ADDR_SPEED, `PONG_DEF_SPEED);
        apb_write(`PONG_ADDR_GRAVITY, `PONG_DEF_GRAVITY);
        apb_write(`PONG_ADDR_WIN, 32'h0);
        end_test("apb registers");

        start_game();
        repeat (200) do_frame(1'b0);
        end_test("solo rally");

        n = 0;
        while (solo_st != pong_pkg::S_OVER && n < FRAMES_MAX) begin
            do_frame(1'b1);
            n = n + 1;
        end
        check("game_over", game_over, 1'b1);
        repeat (3) do_frame(1'b1);
        start_game();
        check("game_over", game_over, 1'b0);
        end_test("solo miss");

        // duel side
        #1 sw = 1'b1;
        // duel ball left during the solo tests, a win frees it for a new serve
        apb_write(`PONG_ADDR_WIN, 32'h1);
        apb_write(`PONG_ADDR_WIN, 32'h0);
        start_game();
        trig_count = 0;
        n = 0;
        while (duel_st == pong_pkg::D_PLAY && n < FRAMES_MAX) begin
            do_frame(1'b0);
            n = n + 1;
        end
        check("is_idle", is_idle, 1'b1);
        check("ball_send_trigger count", trig_count, 1);
        check("ball_vy at send", trig_vy, duel_mdl.vy);
        check("gravity_counter at send", trig_gc, duel_mdl.gravity_counter);
        end_test("duel send");

        y_val  = $urandom_range(479, 0);
        vy_val = int'($urandom_range(120, 0)) - 60;
        apb_write(`PONG_ADDR_Y0, y_val & 8'hFF);
        apb_write(`PONG_ADDR_Y1, y_val >> 8);
        apb_write(`PONG_ADDR_VY, vy_val & 8'hFF);
        apb_write(`PONG_ADDR_SPEED, $urandom_range(8, 4));   // round trip fits in a test
        apb_write(`PONG_ADDR_GO, $urandom);
        repeat (2) @(posedge clk_25MHZ);
        #1 compare_ports();
        check("ball_x_out", ball_x_out, `PONG_X_MAX);
        check("ball_y_out", ball_y_out, y_val);
        n = 0;
        while (duel_st == pong_pkg::D_PLAY && n < FRAMES_MAX) begin
            do_frame(1'b0);
            n = n + 1;
        end
        apb_write(`PONG_ADDR_WIN, 32'h1);
        repeat (2) @(posedge clk_25MHZ);
        #1 check("is_you_win", is_you_win, 1'b1);
        apb_write(`PONG_ADDR_WIN, 32'h0);
        end_test("duel receive");

        // both controllers keep running while only one is shown
        start_game();
        for (int i = 0; i < 120; i++) begin
            if (i % 30 == 0) begin
                @(posedge clk_25MHZ);
                #1 sw = ~sw;
                #1 compare_ports();
            end
            do_frame(1'b0);
        end
        end_test("mode switch");

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pong_game.f */
+incdir+.
pong_pkg.sv
ball_motion.sv
game_solo_ctrl.sv
game_duel_ctrl.sv
ball_link_regs.sv
top_game_controller.sv
tb_top_game_controller.sv
